// ==== logic/mdu_op_pkg.sv ====
package mdu_op_pkg;

  //////////////////////////////////////////////////
  // M extension operations, encoded as funct3
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    op_mul    = 3'b000,
    op_mulh   = 3'b001,
    op_mulhsu = 3'b010,
    op_mulhu  = 3'b011,
    op_div    = 3'b100,
    op_divu   = 3'b101,
    op_rem    = 3'b110,
    op_remu   = 3'b111
  } mdu_op_e;

  // Divide group has funct3 bit 2 set
  function automatic logic is_div(mdu_op_e op);
    logic [2:0] code;
    code = op;
    return code[2];
  endfunction

  // Operand a is signed for everything but the unsigned forms
  function automatic logic a_signed(mdu_op_e op);
    return (op == op_mul) || (op == op_mulh) || (op == op_mulhsu) ||
           (op == op_div) || (op == op_rem);
  endfunction

  // Operand b is unsigned for MULHSU as well
  function automatic logic b_signed(mdu_op_e op);
    return (op == op_mul) || (op == op_mulh) || (op == op_div) || (op == op_rem);
  endfunction

endpackage

// ==== logic/mdu_bus_pkg.sv ====
package mdu_bus_pkg;

  // Architectural operand and result width
  typedef logic [31:0] word_t;

  // One request to the unit
  typedef struct packed {
    mdu_op_pkg::mdu_op_e op;
    word_t               a;
    word_t               b;
  } mdu_req_t;

  //////////////////////////////////////////////////
  // Wide engine result, same 64 bits read two ways
  //////////////////////////////////////////////////

  // Multiplier view, full product
  typedef struct packed {
    word_t hi;
    word_t lo;
  } mul_view_t;

  // Divider view, remainder on top
  typedef struct packed {
    word_t rem;
    word_t quo;
  } div_view_t;

  typedef union packed {
    mul_view_t mul;
    div_view_t div;
  } wide_u;

endpackage

// ==== logic/multiplier_unsigned.sv ====
module multiplier_unsigned (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               start_i,
  input  mdu_bus_pkg::word_t a_i,
  input  mdu_bus_pkg::word_t b_i,
  input  logic               a_sign_i,
  input  logic               b_sign_i,
  output mdu_bus_pkg::wide_u product_o,
  output logic               a_sign_o,
  output logic               b_sign_o,
  output logic               done_o
);

  // Shifted multiplicand, grows left each step
  logic [63:0] mcand_q;
  // Multiplier, consumed from bit 0
  logic [31:0] mplier_q;
  // Running partial product
  logic [63:0] acc_q;
  logic [5:0]  count_q;
  logic        running_q;
  logic        done_q;
  logic        a_sign_q;
  logic        b_sign_q;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      running_q <= 1'b0;
      count_q   <= 6'd0;
      done_q    <= 1'b0;
    end else begin
      // Pulse by default
      done_q <= 1'b0;
      if (start_i) begin
        running_q <= 1'b1;
        count_q   <= 6'd0;
      end else if (running_q) begin
        count_q <= count_q + 6'd1;
        // Last step lands here, product valid with done
        if (count_q == 6'd31) begin
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Shift-add datapath
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      mcand_q  <= {32'd0, a_i};
      mplier_q <= b_i;
      acc_q    <= 64'd0;
      // Signs captured now, operands may move on before done
      a_sign_q <= a_sign_i;
      b_sign_q <= b_sign_i;
    end else if (running_q) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign product_o.mul = '{hi: acc_q[63:32], lo: acc_q[31:0]};
  assign a_sign_o      = a_sign_q;
  assign b_sign_o      = b_sign_q;
  assign done_o        = done_q;

  // One-cycle done
  done_pulse_a: assert property (@(posedge clk_i) disable iff (reset_i)
    done_q |=> !done_q);

  // Never runs past 32 steps
  count_range_a: assert property (@(posedge clk_i) disable iff (reset_i)
    count_q <= 6'd32);

endmodule

// ==== logic/multiplier_top.sv ====
module multiplier_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  start_i,
  input  mdu_bus_pkg::mdu_req_t req_i,
  output mdu_bus_pkg::wide_u    result_o,
  output logic                  done_o
);

  // Operand is negative and the op treats it as signed
  logic               a_neg;
  logic               b_neg;
  mdu_bus_pkg::word_t a_mag;
  mdu_bus_pkg::word_t b_mag;
  mdu_bus_pkg::wide_u core_prod;
  logic               a_sign;
  logic               b_sign;
  logic               core_done;
  logic [63:0]        prod_mag;
  logic [63:0]        prod_signed;
  logic               negate;

  //////////////////////////////////////////////////
  // Pre-processing to magnitudes
  //////////////////////////////////////////////////

  // MULHU leaves both alone, MULHSU only a
  assign a_neg = mdu_op_pkg::a_signed(req_i.op) & req_i.a[31];
  assign b_neg = mdu_op_pkg::b_signed(req_i.op) & req_i.b[31];

  assign a_mag = a_neg ? (~req_i.a + 32'd1) : req_i.a;
  assign b_mag = b_neg ? (~req_i.b + 32'd1) : req_i.b;

  // Unsigned core, also holds the effective signs
  multiplier_unsigned multiplier_unsigned_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .start_i   (start_i),
    .a_i       (a_mag),
    .b_i       (b_mag),
    .a_sign_i  (a_neg),
    .b_sign_i  (b_neg),
    .product_o (core_prod),
    .a_sign_o  (a_sign),
    .b_sign_o  (b_sign),
    .done_o    (core_done)
  );

  //////////////////////////////////////////////////
  // Post-negation
  //////////////////////////////////////////////////

  assign prod_mag = {core_prod.mul.hi, core_prod.mul.lo};

  // Unsigned operands already have sign zero here,
  // so one XOR covers every op
  assign negate      = a_sign ^ b_sign;
  assign prod_signed = negate ? (~prod_mag + 64'd1) : prod_mag;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= core_done;
    end
  end

  // Last product held until the next one completes
  always_ff @(posedge clk_i) begin
    if (core_done) begin
      result_o.mul <= '{hi: prod_signed[63:32], lo: prod_signed[31:0]};
    end
  end

endmodule

// ==== logic/divider_unsigned.sv ====
module divider_unsigned (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               start_i,
  input  mdu_bus_pkg::word_t dividend_i,
  input  mdu_bus_pkg::word_t divisor_i,
  output mdu_bus_pkg::wide_u result_o,
  output logic               done_o
);

  // Dividend bits leave at the top, quotient bits enter at the bottom
  logic [31:0] quo_q;
  // Partial remainder
  logic [31:0] rem_q;
  logic [31:0] divisor_q;
  logic [5:0]  count_q;
  logic        running_q;
  logic        done_q;
  // Trial step
  logic [32:0] shifted;
  logic [32:0] diff;
  logic        fits;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      running_q <= 1'b0;
      count_q   <= 6'd0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        running_q <= 1'b1;
        count_q   <= 6'd0;
      end else if (running_q) begin
        count_q <= count_q + 6'd1;
        // Step 32 finishes here
        if (count_q == 6'd31) begin
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Restoring step
  //////////////////////////////////////////////////

  // Bring the next dividend bit down
  assign shifted = {rem_q, quo_q[31]};
  assign diff    = shifted - {1'b0, divisor_q};
  // No borrow means the divisor fits
  assign fits    = ~diff[32];

  // Zero divisor always fits, so quotient fills with ones
  // and the remainder collects the dividend unchanged
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      quo_q     <= dividend_i;
      rem_q     <= 32'd0;
      divisor_q <= divisor_i;
    end else if (running_q) begin
      rem_q <= fits ? diff[31:0] : shifted[31:0];
      quo_q <= {quo_q[30:0], fits};
    end
  end

  assign result_o.div = '{rem: rem_q, quo: quo_q};
  assign done_o       = done_q;

  // Done lasts one cycle
  done_pulse_a: assert property (@(posedge clk_i) disable iff (reset_i)
    done_q |=> !done_q);

endmodule

// ==== logic/divider_top.sv ====
module divider_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  start_i,
  input  mdu_bus_pkg::mdu_req_t req_i,
  output mdu_bus_pkg::wide_u    result_o,
  output logic                  done_o
);

  logic               a_neg;
  logic               b_neg;
  mdu_bus_pkg::word_t a_mag;
  mdu_bus_pkg::word_t b_mag;
  // Held from start to the end of the operation
  logic               a_neg_q;
  logic               b_neg_q;
  logic               b_zero_q;
  mdu_bus_pkg::wide_u core_res;
  logic               core_done;
  logic               quo_neg;
  logic               rem_neg;
  mdu_bus_pkg::word_t quo_signed;
  mdu_bus_pkg::word_t rem_signed;

  //////////////////////////////////////////////////
  // Magnitudes and latched flags
  //////////////////////////////////////////////////

  // DIVU and REMU see both operands as unsigned
  assign a_neg = mdu_op_pkg::a_signed(req_i.op) & req_i.a[31];
  assign b_neg = mdu_op_pkg::b_signed(req_i.op) & req_i.b[31];

  // Most negative value maps onto itself, 0x80000000,
  // read as unsigned that is 2^31, the right magnitude
  assign a_mag = a_neg ? (~req_i.a + 32'd1) : req_i.a;
  assign b_mag = b_neg ? (~req_i.b + 32'd1) : req_i.b;

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      a_neg_q  <= a_neg;
      b_neg_q  <= b_neg;
      b_zero_q <= (req_i.b == 32'd0);
    end
  end

  divider_unsigned divider_unsigned_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .start_i    (start_i),
    .dividend_i (a_mag),
    .divisor_i  (b_mag),
    .result_o   (core_res),
    .done_o     (core_done)
  );

  //////////////////////////////////////////////////
  // Sign rules
  //////////////////////////////////////////////////

  // All-ones quotient from a zero divisor stays as it is
  assign quo_neg = (a_neg_q ^ b_neg_q) & ~b_zero_q;
  // Remainder follows the dividend
  assign rem_neg = a_neg_q;

  // Overflow case of min / -1
  // 2^31 / 1 gives 2^31 and remainder 0, and with both signs
  // negative the quotient is left as 0x80000000, the ISA result
  assign quo_signed = quo_neg ? (~core_res.div.quo + 32'd1) : core_res.div.quo;
  assign rem_signed = rem_neg ? (~core_res.div.rem + 32'd1) : core_res.div.rem;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= core_done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (core_done) begin
      result_o.div <= '{rem: rem_signed, quo: quo_signed};
    end
  end

endmodule

// ==== logic/mdu_top.sv ====
module mdu_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  start_i,
  input  mdu_bus_pkg::mdu_req_t req_i,
  output mdu_bus_pkg::word_t    result_o,
  output logic                  done_o
);

  logic                busy_q;
  mdu_op_pkg::mdu_op_e op_q;
  logic                accept;
  logic                mul_start;
  logic                div_start;
  mdu_bus_pkg::wide_u  mul_res;
  mdu_bus_pkg::wide_u  div_res;
  logic                mul_done;
  logic                div_done;
  logic                eng_done;
  mdu_bus_pkg::wide_u  sel_res;
  mdu_bus_pkg::word_t  res_word;

  // Starts while busy are dropped
  assign accept    = start_i & ~busy_q;
  assign div_start = accept & mdu_op_pkg::is_div(req_i.op);
  assign mul_start = accept & ~mdu_op_pkg::is_div(req_i.op);
  assign eng_done  = mul_done | div_done;

  multiplier_top multiplier_top_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .start_i  (mul_start),
    .req_i    (req_i),
    .result_o (mul_res),
    .done_o   (mul_done)
  );

  divider_top divider_top_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .start_i  (div_start),
    .req_i    (req_i),
    .result_o (div_res),
    .done_o   (div_done)
  );

  //////////////////////////////////////////////////
  // Result word select by the op that was started
  //////////////////////////////////////////////////

  assign sel_res = mdu_op_pkg::is_div(op_q) ? div_res : mul_res;

  always_comb begin
    case (op_q)
      mdu_op_pkg::op_mul:                        res_word = sel_res.mul.lo;
      mdu_op_pkg::op_mulh, mdu_op_pkg::op_mulhsu,
      mdu_op_pkg::op_mulhu:                      res_word = sel_res.mul.hi;
      mdu_op_pkg::op_div, mdu_op_pkg::op_divu:   res_word = sel_res.div.quo;
      default:                                   res_word = sel_res.div.rem;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= req_i.op;
    end
  end

  // Busy from accept to engine done, one registered cycle to the port
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q   <= 1'b0;
      done_o   <= 1'b0;
      result_o <= '0;
    end else begin
      done_o <= eng_done;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (eng_done) begin
        busy_q <= 1'b0;
      end
      if (eng_done) begin
        result_o <= res_word;
      end
    end
  end

  // Only one engine runs at a time
  one_engine_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(mul_done && div_done));

endmodule

// ==== verif/mdu_tb.sv ====
module mdu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_DIRECTED     = 30;
  localparam int N_RANDOM       = 16;
  localparam int N_TESTS        = N_DIRECTED + N_RANDOM;
  // Start edge to done_o edge
  localparam int LATENCY        = 34;
  localparam int DONE_WAIT      = 36;
  localparam int TIMEOUT_CYCLES = N_TESTS * 40 + 20;

  // One table row, probe marks a second start while busy
  typedef struct packed {
    mdu_op_pkg::mdu_op_e op;
    mdu_bus_pkg::word_t  a;
    mdu_bus_pkg::word_t  b;
    mdu_bus_pkg::word_t  exp;
    logic                probe;
  } test_t;

  logic                  clk_i;
  logic                  reset_i;
  logic                  start_i;
  mdu_bus_pkg::mdu_req_t req_i;
  mdu_bus_pkg::word_t    result_o;
  logic                  done_o;

  test_t  tests [N_TESTS];
  int     n_filled;
  int     error_count;
  int     pass_count;
  int     fail_count;
  int     cycle_count;
  integer seed;

  mdu_top mdu_top_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .start_i  (start_i),
    .req_i    (req_i),
    .result_o (result_o),
    .done_o   (done_o)
  );

  always #50 clk_i = ~clk_i;

  // Hard stop if the DUT stalls
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped at %0t: cycle limit of %0d reached", $time, TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model, 64-bit arithmetic
  //////////////////////////////////////////////////

  function automatic mdu_bus_pkg::word_t expected_result(
    mdu_op_pkg::mdu_op_e op, mdu_bus_pkg::word_t a, mdu_bus_pkg::word_t b);
    longint             sa;
    longint             sb;
    longint unsigned    ua;
    longint unsigned    ub;
    logic [63:0]        p;
    mdu_bus_pkg::word_t r;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = {32'd0, a};
    ub = {32'd0, b};
    p  = 64'd0;
    r  = 32'd0;
    case (op)
      mdu_op_pkg::op_mul: begin
        p = ua * ub;
        r = p[31:0];
      end
      mdu_op_pkg::op_mulh: begin
        p = sa * sb;
        r = p[63:32];
      end
      // b zero-extended, still fits a signed longint
      mdu_op_pkg::op_mulhsu: begin
        p = sa * longint'(ub);
        r = p[63:32];
      end
      mdu_op_pkg::op_mulhu: begin
        p = ua * ub;
        r = p[63:32];
      end
      // min / -1 is 2^31 in 64 bits, low word is min again
      mdu_op_pkg::op_div: begin
        p = (b == 32'd0) ? -64'sd1 : sa / sb;
        r = p[31:0];
      end
      mdu_op_pkg::op_rem: begin
        p = (b == 32'd0) ? sa : sa % sb;
        r = p[31:0];
      end
      mdu_op_pkg::op_divu: begin
        p = (b == 32'd0) ? 64'hFFFF_FFFF_FFFF_FFFF : ua / ub;
        r = p[31:0];
      end
      default: begin
        p = (b == 32'd0) ? ua : ua % ub;
        r = p[31:0];
      end
    endcase
    return r;
  endfunction

  task automatic add_test(input mdu_op_pkg::mdu_op_e op, input mdu_bus_pkg::word_t a,
                          input mdu_bus_pkg::word_t b, input mdu_bus_pkg::word_t exp,
                          input logic probe);
    tests[n_filled] = '{op: op, a: a, b: b, exp: exp, probe: probe};
    n_filled++;
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_result(input mdu_bus_pkg::word_t got, input mdu_bus_pkg::word_t exp,
                              input int idx);
    if (got !== exp) begin
      $display("FAILED %0t: entry %0d result %h, expected %h", $time, idx, got, exp);
      error_count++;
    end
  endtask

  task automatic check_latency(input int cycles, input int idx);
    if (cycles != LATENCY) begin
      $display("FAILED %0t: entry %0d done after %0d cycles, expected %0d",
               $time, idx, cycles, LATENCY);
      error_count++;
    end
  endtask

  // Start one entry, wait for done_o, check value, latency and pulse width
  task automatic run_test(input int idx);
    test_t              t;
    int                 cycles;
    bit                 seen;
    int                 err_before;
    mdu_bus_pkg::word_t got;
    t          = tests[idx];
    err_before = error_count;
    seen       = 1'b0;
    cycles     = 0;
    got        = 32'd0;
    @(negedge clk_i);
    req_i   = '{op: t.op, a: t.a, b: t.b};
    start_i = 1'b1;
    while (!seen && cycles < DONE_WAIT) begin
      @(negedge clk_i);
      start_i = 1'b0;
      if (done_o) begin
        seen = 1'b1;
        got  = result_o;
      end else begin
        cycles++;
        // Operands move on, engines must use what they latched
        if (cycles == 1) begin
          req_i.a = ~t.a;
          req_i.b = ~t.b;
        end
        // Second request in the middle of the first
        if (t.probe && cycles == 10) begin
          req_i   = '{op: mdu_op_pkg::op_divu, a: 32'hDEAD_BEEF, b: 32'd3};
          start_i = 1'b1;
        end
      end
    end
    if (!seen) begin
      $display("Entry %0d: done_o never came within %0d cycles of start", idx, DONE_WAIT);
      error_count++;
    end else begin
      check_result(got, t.exp, idx);
      check_latency(cycles, idx);
      @(negedge clk_i);
      if (done_o) begin
        $display("FAILED %0t: entry %0d done_o high for more than one cycle", $time, idx);
        error_count++;
      end
    end
    if (error_count == err_before) begin
      pass_count++;
      $display("Entry %0d %s a=%h b=%h result=%h ok", idx, t.op.name(), t.a, t.b, got);
    end else begin
      fail_count++;
      $display("Entry %0d %s a=%h b=%h result=%h bad", idx, t.op.name(), t.a, t.b, got);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    mdu_op_pkg::mdu_op_e op;
    mdu_bus_pkg::word_t  a;
    mdu_bus_pkg::word_t  b;
    logic [31:0]         r;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    start_i     = 1'b0;
    req_i       = '0;
    n_filled    = 0;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    cycle_count = 0;
    seed        = 20;

    // Multiply, unsigned and large
    add_test(mdu_op_pkg::op_mul,    32'd3,         32'd5,         32'h0000_000F, 1'b0);
    add_test(mdu_op_pkg::op_mul,    32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0);
    add_test(mdu_op_pkg::op_mulhu,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 1'b0);
    add_test(mdu_op_pkg::op_mulhu,  32'h8000_0000, 32'd2,         32'h0000_0001, 1'b0);
    // Signed high words, every sign pairing
    add_test(mdu_op_pkg::op_mulh,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0);
    add_test(mdu_op_pkg::op_mulh,   32'hFFFF_FFFE, 32'd3,         32'hFFFF_FFFF, 1'b0);
    add_test(mdu_op_pkg::op_mulh,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 1'b0);
    add_test(mdu_op_pkg::op_mulh,   32'h8000_0000, 32'h7FFF_FFFF, 32'hC000_0000, 1'b0);
    add_test(mdu_op_pkg::op_mulh,   32'h7FFF_FFFF, 32'h8000_0000, 32'hC000_0000, 1'b0);
    add_test(mdu_op_pkg::op_mulh,   32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h3FFF_FFFF, 1'b0);
    add_test(mdu_op_pkg::op_mulhsu, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0);
    add_test(mdu_op_pkg::op_mulhsu, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 1'b0);
    add_test(mdu_op_pkg::op_mulhsu, 32'h7FFF_FFFF, 32'h8000_0000, 32'h3FFF_FFFF, 1'b0);
    add_test(mdu_op_pkg::op_mul,    32'hFFFF_FFFD, 32'd7,         32'hFFFF_FFEB, 1'b0);
    // Truncating division, mixed signs
    add_test(mdu_op_pkg::op_div,    32'd20,        32'hFFFF_FFFD, 32'hFFFF_FFFA, 1'b0);
    add_test(mdu_op_pkg::op_rem,    32'd20,        32'hFFFF_FFFD, 32'h0000_0002, 1'b0);
    add_test(mdu_op_pkg::op_div,    32'hFFFF_FFEC, 32'd3,         32'hFFFF_FFFA, 1'b0);
    add_test(mdu_op_pkg::op_rem,    32'hFFFF_FFEC, 32'd3,         32'hFFFF_FFFE, 1'b0);
    add_test(mdu_op_pkg::op_div,    32'hFFFF_FFEC, 32'hFFFF_FFFD, 32'h0000_0006, 1'b0);
    add_test(mdu_op_pkg::op_rem,    32'hFFFF_FFEC, 32'hFFFF_FFFD, 32'hFFFF_FFFE, 1'b0);
    add_test(mdu_op_pkg::op_divu,   32'hFFFF_FFFF, 32'h10,        32'h0FFF_FFFF, 1'b0);
    add_test(mdu_op_pkg::op_remu,   32'hFFFF_FFFF, 32'h10,        32'h0000_000F, 1'b0);
    // Divide by zero and signed overflow
    add_test(mdu_op_pkg::op_div,    32'd7,         32'd0,         32'hFFFF_FFFF, 1'b0);
    add_test(mdu_op_pkg::op_rem,    32'hFFFF_FFF9, 32'd0,         32'hFFFF_FFF9, 1'b0);
    add_test(mdu_op_pkg::op_divu,   32'h1234_5678, 32'd0,         32'hFFFF_FFFF, 1'b0);
    add_test(mdu_op_pkg::op_remu,   32'h1234_5678, 32'd0,         32'h1234_5678, 1'b0);
    add_test(mdu_op_pkg::op_div,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 1'b0);
    add_test(mdu_op_pkg::op_rem,    32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0);
    // Start while busy, must be dropped
    add_test(mdu_op_pkg::op_mul,    32'd1000,      32'd1000,      32'h000F_4240, 1'b1);
    add_test(mdu_op_pkg::op_div,    32'd100,       32'd7,         32'h0000_000E, 1'b1);

    if (n_filled != N_DIRECTED) begin
      $display("Directed table holds %0d entries instead of %0d", n_filled, N_DIRECTED);
      error_count++;
    end

    // Random rows, small divisors now and then
    repeat (N_RANDOM) begin
      r  = $random(seed);
      op = mdu_op_pkg::mdu_op_e'(r[2:0]);
      a  = $random(seed);
      b  = $random(seed);
      if (r[2] && r[3]) begin
        b = b & 32'h0000_00FF;
      end
      add_test(op, a, b, expected_result(op, a, b), 1'b0);
    end

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    if (done_o !== 1'b0 || result_o !== 32'd0) begin
      $display("FAILED %0t: outputs not cleared by reset, done_o=%b result_o=%h",
               $time, done_o, result_o);
      error_count++;
    end

    for (int i = 0; i < N_TESTS; i++) begin
      run_test(i);
    end

    $display("Entries %0d, passed %0d, failed %0d, errors %0d",
             N_TESTS, pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/mdu_op_pkg.sv
logic/mdu_bus_pkg.sv
logic/multiplier_unsigned.sv
logic/multiplier_top.sv
logic/divider_unsigned.sv
logic/divider_top.sv
logic/mdu_top.sv
verif/mdu_tb.sv
